// ==== branch_unit.f ====
logic/branch_pkg.sv
logic/branch_write_if.sv
logic/branch_table.sv
logic/branch_check.sv
logic/branch_unit.sv
test/branch_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the branch unit testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -Wno-fatal \
    --top-module branch_unit_tb -f branch_unit.f -o branch_unit_sim

./obj_dir/branch_unit_sim > sim.log 2>&1
cat sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
if ! grep -q "Simulation passed" sim.log; then
    echo "no result found in sim.log"
    exit 1
fi
exit 0

// ==== test/branch_unit_tb.sv ====
/*
 * branch unit testbench
 * directed tests against shadow tables and a reference model of the
 * two-cycle branch pipeline, with random flags and pcs from an LFSR
 */

`timescale 1ns/1ps

module branch_unit_tb
    import branch_pkg::*;
();

    localparam int THREAD_COUNT = 8;
    localparam int ENTRY_COUNT = 2;
    localparam int TW = index_width(THREAD_COUNT);
    localparam int EW = index_width(ENTRY_COUNT);
    localparam logic [31:0] LFSR_SEED = 32'hc489;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;

    logic clock;
    logic rst_n;
    logic [PC_WIDTH-1:0] pc;
    logic [FLAGS_WIDTH-1:0] flags;
    logic io_ready_previous;
    logic jump_previous;
    logic wren_origin;
    logic wren_destination;
    logic wren_condition;
    logic [EW+TW-1:0] write_addr;
    logic [PC_WIDTH-1:0] write_origin;
    logic [PC_WIDTH-1:0] write_destination;
    logic [COND_WIDTH-1:0] write_condition;
    logic [TW-1:0] issue_thread;
    logic [PC_WIDTH-1:0] branch_destination;
    logic jump;

    // shadow copies of every field written into the DUT
    logic [PC_WIDTH-1:0] sh_origin [ENTRY_COUNT][THREAD_COUNT];
    logic [PC_WIDTH-1:0] sh_dest [ENTRY_COUNT][THREAD_COUNT];
    logic [COND_WIDTH-1:0] sh_cond [ENTRY_COUNT][THREAD_COUNT];

    // write waiting to go out with the next driven cycle
    logic write_pending;
    // field strobes of that write, origin on top and condition at the bottom
    logic [2:0] pend_fields;
    logic [EW+TW-1:0] pend_addr;
    logic [PC_WIDTH-1:0] pend_origin;
    logic [PC_WIDTH-1:0] pend_dest;
    logic [COND_WIDTH-1:0] pend_cond;

    // expected {jump, destination} of the issues still in the pipeline
    logic [PC_WIDTH:0] expected_q [$];
    int exp_thread;
    logic [31:0] lfsr_state;
    string cur_test;
    int errors;
    int checks;
    int test_errors;
    int tests_run;
    int tests_failed;

    branch_unit DUT (.*);

    initial clock = 1'b0;
    always #50 clock = ~clock;

    // ----------------------------------------
    // stimulus and reference model
    // ----------------------------------------

    // each bit taken costs one step of the Galois LFSR
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r[i] = lfsr_state[0];
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
        end
        return r;
    endfunction

    function automatic logic cond_holds(input logic [COND_WIDTH-1:0] code,
                                        input logic [FLAGS_WIDTH-1:0] f);
        int sel;
        sel = int'(code) - int'(COND_FLAG_BASE);
        if (code == COND_NEVER) return 1'b0;
        if (code == COND_ALWAYS) return 1'b1;
        // codes above the flag range are spare and never jump
        if (sel >= 0 && sel < FLAGS_WIDTH) return f[sel];
        return 1'b0;
    endfunction

    // result of one issue, OR over all entries of the thread
    function automatic logic [PC_WIDTH:0] predict(input int t, input logic [PC_WIDTH-1:0] p,
                                                  input logic [FLAGS_WIDTH-1:0] f,
                                                  input logic io, input logic jp);
        logic [PC_WIDTH-1:0] dst;
        logic jmp;
        logic taken;
        dst = '0;
        jmp = 1'b0;
        for (int e = 0; e < ENTRY_COUNT; e++) begin
            // a stalled instruction keeps its earlier decision
            taken = (io ? cond_holds(sh_cond[e][t], f) : jp) && (p == sh_origin[e][t]);
            if (taken) begin
                dst = dst | sh_dest[e][t];
                jmp = 1'b1;
            end
        end
        return {jmp, dst};
    endfunction

    task automatic check_equal(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (exp == act) else begin
            $display("Mismatch in %s, %s: expected %0h, actual %0h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    // each call is one clock cycle that drives the issue of the next thread and
    // then compares the outputs with the issue that went in two cycles earlier
    task automatic step(input logic [PC_WIDTH-1:0] p, input logic [FLAGS_WIDTH-1:0] f,
                        input logic io, input logic jp);
        logic [PC_WIDTH:0] exp_old;
        @(posedge clock);
        exp_thread = (exp_thread + 1) % THREAD_COUNT;
        pc <= p;
        flags <= f;
        io_ready_previous <= io;
        jump_previous <= jp;
        wren_origin <= write_pending && pend_fields[2];
        wren_destination <= write_pending && pend_fields[1];
        wren_condition <= write_pending && pend_fields[0];
        write_addr <= pend_addr;
        write_origin <= pend_origin;
        write_destination <= pend_dest;
        write_condition <= pend_cond;
        write_pending = 1'b0;
        @(negedge clock);
        check_equal("issue_thread", 32'(exp_thread), 32'(issue_thread));
        expected_q.push_back(predict(exp_thread, p, f, io, jp));
        exp_old = expected_q.pop_front();
        check_equal("jump", 32'(exp_old[PC_WIDTH]), 32'(jump));
        check_equal("branch_destination", 32'(exp_old[PC_WIDTH-1:0]), 32'(branch_destination));
    endtask

    task automatic idle_step();
        step(PC_WIDTH'(rand_bits(PC_WIDTH)), FLAGS_WIDTH'(rand_bits(FLAGS_WIDTH)), 1'b1,
             1'(rand_bits(1)));
    endtask

    task automatic wait_for_thread(input int k);
        int guard;
        guard = 0;
        while ((int'(issue_thread) + 1) % THREAD_COUNT != k && guard <= 2 * THREAD_COUNT) begin
            idle_step();
            guard++;
        end
        if (guard > 2 * THREAD_COUNT) begin
            $display("timeout: issue_thread never came round to thread %0d", k);
            $display("Simulation failed");
            $finish;
        end
    endtask

    task automatic issue_at(input int k, input logic [PC_WIDTH-1:0] p,
                            input logic [FLAGS_WIDTH-1:0] f, input logic io, input logic jp);
        wait_for_thread(k);
        step(p, f, io, jp);
    endtask

    // the write lands at the end of its cycle and is read from the cycle after next,
    // only the fields whose strobe is set change
    task automatic write_fields(input int e, input int t, input logic [2:0] fields,
                                input logic [PC_WIDTH-1:0] org,
                                input logic [PC_WIDTH-1:0] dst,
                                input logic [COND_WIDTH-1:0] cond);
        write_pending = 1'b1;
        pend_fields = fields;
        pend_addr = {EW'(e), TW'(t)};
        pend_origin = org;
        pend_dest = dst;
        pend_cond = cond;
        idle_step();
        idle_step();
        if (fields[2]) sh_origin[e][t] = org;
        if (fields[1]) sh_dest[e][t] = dst;
        if (fields[0]) sh_cond[e][t] = cond;
    endtask

    task automatic write_entry(input int e, input int t, input logic [PC_WIDTH-1:0] org,
                               input logic [PC_WIDTH-1:0] dst, input logic [COND_WIDTH-1:0] cond);
        write_fields(e, t, 3'b111, org, dst, cond);
    endtask

    // the issue just stepped reaches the outputs after two more cycles
    task automatic expect_result(input logic exp_jump, input logic [PC_WIDTH-1:0] exp_dest);
        idle_step();
        idle_step();
        check_equal("jump", 32'(exp_jump), 32'(jump));
        check_equal("branch_destination", 32'(exp_dest), 32'(branch_destination));
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors != test_errors) tests_failed++;
        $display("%-20s %s, %0d errors", cur_test, (errors == test_errors) ? "ok" : "FAILED",
                 errors - test_errors);
    endtask

    // ----------------------------------------
    // directed tests
    // ----------------------------------------

    task automatic reset_state();
        begin_test("reset");
        check_equal("issue_thread", 32'd0, 32'(issue_thread));
        check_equal("jump", 32'd0, 32'(jump));
        check_equal("branch_destination", 32'd0, 32'(branch_destination));
        repeat (2 * THREAD_COUNT) idle_step();
        end_test();
    endtask

    task automatic unconditional_branch();
        begin_test("unconditional");
        write_entry(0, 3, 10'h155, 10'h2a3, COND_ALWAYS);
        issue_at(3, 10'h155, 8'h00, 1'b1, 1'b0);
        expect_result(1'b1, 10'h2a3);
        issue_at(3, 10'h154, 8'hff, 1'b1, 1'b1);
        expect_result(1'b0, 10'h000);
        // same pc on another thread finds that thread's empty slot
        issue_at(5, 10'h155, 8'hff, 1'b1, 1'b0);
        expect_result(1'b0, 10'h000);
        end_test();
    endtask

    task automatic flag_conditions();
        begin_test("flag conditions");
        for (int code = 0; code < (1 << COND_WIDTH); code++) begin
            write_entry(1, 6, 10'h0c7, 10'h31e, COND_WIDTH'(code));
            repeat (4) begin
                issue_at(6, 10'h0c7, FLAGS_WIDTH'(rand_bits(FLAGS_WIDTH)), 1'b1, 1'(rand_bits(1)));
            end
        end
        write_entry(1, 6, 10'h0c7, 10'h31e, COND_NEVER);
        end_test();
    endtask

    task automatic io_override();
        begin_test("io override");
        // condition watches flag 5
        write_entry(0, 2, 10'h2e0, 10'h111, COND_FLAG_BASE + 4'd5);
        issue_at(2, 10'h2e0, 8'h00, 1'b0, 1'b1);
        expect_result(1'b1, 10'h111);
        issue_at(2, 10'h2e0, 8'hff, 1'b0, 1'b0);
        expect_result(1'b0, 10'h000);
        issue_at(2, 10'h2e0, 8'h20, 1'b1, 1'b0);
        expect_result(1'b1, 10'h111);
        repeat (8) begin
            issue_at(2, 10'h2e0, FLAGS_WIDTH'(rand_bits(FLAGS_WIDTH)), 1'(rand_bits(1)),
                     1'(rand_bits(1)));
        end
        end_test();
    endtask

    task automatic several_entries();
        begin_test("several entries");
        write_entry(0, 5, 10'h040, 10'h201, COND_ALWAYS);
        write_entry(1, 5, 10'h080, 10'h012, COND_ALWAYS);
        issue_at(5, 10'h040, 8'h00, 1'b1, 1'b0);
        expect_result(1'b1, 10'h201);
        issue_at(5, 10'h080, 8'h00, 1'b1, 1'b0);
        expect_result(1'b1, 10'h012);
        // entry 1 moves onto the same origin while the rotation keeps going,
        // its condition strobe stays low so it keeps ALWAYS
        write_fields(1, 5, 3'b110, 10'h040, 10'h104, COND_NEVER);
        issue_at(5, 10'h040, 8'h00, 1'b1, 1'b0);
        expect_result(1'b1, 10'h305);
        issue_at(5, 10'h080, 8'h00, 1'b1, 1'b0);
        expect_result(1'b0, 10'h000);
        end_test();
    endtask

    initial begin
        lfsr_state = LFSR_SEED;
        rst_n = 1'b0;
        pc = '0;
        flags = '0;
        io_ready_previous = 1'b0;
        jump_previous = 1'b0;
        wren_origin = 1'b0;
        wren_destination = 1'b0;
        wren_condition = 1'b0;
        write_addr = '0;
        write_origin = '0;
        write_destination = '0;
        write_condition = '0;
        write_pending = 1'b0;
        pend_fields = '0;
        pend_addr = '0;
        pend_origin = '0;
        pend_dest = '0;
        pend_cond = '0;
        errors = 0;
        checks = 0;
        tests_run = 0;
        tests_failed = 0;
        exp_thread = 0;
        for (int e = 0; e < ENTRY_COUNT; e++) begin
            for (int t = 0; t < THREAD_COUNT; t++) begin
                sh_origin[e][t] = '0;
                sh_dest[e][t] = '0;
                sh_cond[e][t] = COND_NEVER;
            end
        end
        // the two issues before the first driven cycle never jump
        expected_q.push_back('0);
        expected_q.push_back('0);
        repeat (16) @(posedge clock);
        rst_n <= 1'b1;
        @(negedge clock);
        reset_state();
        unconditional_branch();
        flag_conditions();
        io_override();
        several_entries();
        $display("tests %0d, failed %0d, checks %0d, errors %0d", tests_run, tests_failed,
                 checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== logic/branch_unit.sv ====
/*
 * barrel processor branch unit
 * per-thread branch entries checked every cycle against the issuing
 * thread, results OR-reduced into one destination and jump
 */

`timescale 1ns/1ps

module branch_unit
    import branch_pkg::*;
#(
    parameter int THREAD_COUNT = 8,
    parameter int ENTRY_COUNT = 2,
    localparam int THREAD_ADDR_WIDTH = index_width(THREAD_COUNT),
    localparam int ENTRY_ADDR_WIDTH = index_width(ENTRY_COUNT),
    localparam int WRITE_ADDR_WIDTH = ENTRY_ADDR_WIDTH + THREAD_ADDR_WIDTH
)
(
    input  logic                            clock,
    input  logic                            rst_n,

    // state of the issuing thread
    input  logic [PC_WIDTH-1:0]             pc,
    input  logic [FLAGS_WIDTH-1:0]          flags,
    input  logic                            io_ready_previous,
    input  logic                            jump_previous,

    // ALU writes into the branch tables
    input  logic                            wren_origin,
    input  logic                            wren_destination,
    input  logic                            wren_condition,
    input  logic [WRITE_ADDR_WIDTH-1:0]     write_addr,
    input  logic [PC_WIDTH-1:0]             write_origin,
    input  logic [PC_WIDTH-1:0]             write_destination,
    input  logic [COND_WIDTH-1:0]           write_condition,

    output logic [THREAD_ADDR_WIDTH-1:0]    issue_thread,
    output logic [PC_WIDTH-1:0]             branch_destination,
    output logic                            jump
);

    logic [THREAD_ADDR_WIDTH-1:0] next_thread;

    logic [PC_WIDTH-1:0] entry_destination [ENTRY_COUNT];
    logic entry_jump [ENTRY_COUNT];

    // ----------------------------------------
    // thread rotation
    // ----------------------------------------

    // explicit wrap so a thread count that is not a power of two works too
    assign next_thread = (issue_thread == THREAD_ADDR_WIDTH'(THREAD_COUNT - 1))
                       ? '0 : issue_thread + 1'b1;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            issue_thread <= '0;
        end else begin
            issue_thread <= next_thread;
        end
    end

    // ----------------------------------------
    // write bus
    // ----------------------------------------

    branch_write_if #(
        .THREAD_COUNT   (THREAD_COUNT),
        .ENTRY_COUNT    (ENTRY_COUNT)
    ) write_bus ();

    assign write_bus.wren_origin = wren_origin;
    assign write_bus.wren_destination = wren_destination;
    assign write_bus.wren_condition = wren_condition;
    assign write_bus.write_addr = write_addr;
    assign write_bus.write_origin = write_origin;
    assign write_bus.write_destination = write_destination;
    assign write_bus.write_condition = write_condition;

    // ----------------------------------------
    // entries
    // ----------------------------------------

    for (genvar e = 0; e < ENTRY_COUNT; e++) begin : gen_entry
        logic [PC_WIDTH-1:0] origin;
        logic [PC_WIDTH-1:0] destination;
        logic [COND_WIDTH-1:0] condition;

        // reads one thread ahead so the fields match issue_thread
        branch_table #(
            .THREAD_COUNT   (THREAD_COUNT),
            .ENTRY_COUNT    (ENTRY_COUNT),
            .ENTRY_INDEX    (e)
        ) table_inst (
            .clock          (clock),
            .rst_n          (rst_n),
            .wr             (write_bus),
            .read_thread    (next_thread),
            .origin         (origin),
            .destination    (destination),
            .condition      (condition)
        );

        branch_check check_inst (
            .clock              (clock),
            .rst_n              (rst_n),
            .pc                 (pc),
            .flags              (flags),
            .io_ready_previous  (io_ready_previous),
            .jump_previous      (jump_previous),
            .origin             (origin),
            .destination        (destination),
            .condition          (condition),
            .destination_out    (entry_destination[e]),
            .jump               (entry_jump[e])
        );
    end

    // ----------------------------------------
    // OR-reduction
    // ----------------------------------------

    // an entry that does not jump outputs zeros, so a plain OR merges them
    always_comb begin
        branch_destination = '0;
        jump = 1'b0;
        for (int e = 0; e < ENTRY_COUNT; e++) begin
            branch_destination = branch_destination | entry_destination[e];
            jump = jump | entry_jump[e];
        end
    end

endmodule

// ==== logic/branch_check.sv ====
/*
 * branch entry check
 * two-stage match of pc against origin and condition against flags,
 * giving a masked destination and jump bit for later OR-reduction
 */

`timescale 1ns/1ps

module branch_check
    import branch_pkg::*;
(
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic [PC_WIDTH-1:0]     pc,
    input  logic [FLAGS_WIDTH-1:0]  flags,
    input  logic                    io_ready_previous,
    input  logic                    jump_previous,
    input  logic [PC_WIDTH-1:0]     origin,
    input  logic [PC_WIDTH-1:0]     destination,
    input  logic [COND_WIDTH-1:0]   condition,
    output logic [PC_WIDTH-1:0]     destination_out,
    output logic                    jump
);

    logic hit;
    logic cond_bit;
    logic [COND_WIDTH-1:0] flag_offset;

    logic hit_s1;
    logic cond_bit_s1;
    logic io_ready_s1;
    logic jump_previous_s1;
    logic [PC_WIDTH-1:0] destination_s1;

    logic decision;
    logic jump_next;

    // ----------------------------------------
    // stage 1 matches origin and condition
    // ----------------------------------------

    assign hit = (pc == origin);

    // offset of the flag bit for the flag codes, ignored for the others
    assign flag_offset = condition - COND_FLAG_BASE;

    always_comb begin
        if (condition == COND_NEVER) begin
            cond_bit = 1'b0;
        end else if (condition == COND_ALWAYS) begin
            cond_bit = 1'b1;
        end else if (condition <= COND_FLAG_LAST) begin
            cond_bit = flags[flag_offset[FLAG_SEL_WIDTH-1:0]];
        end else begin
            // codes past the last flag code are spare and behave as never
            cond_bit = 1'b0;
        end
    end

    // the destination is dropped here already on a miss, so stage 2
    // only has to apply the condition
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            hit_s1 <= 1'b0;
            cond_bit_s1 <= 1'b0;
            io_ready_s1 <= 1'b0;
            jump_previous_s1 <= 1'b0;
            destination_s1 <= '0;
        end else begin
            hit_s1 <= hit;
            cond_bit_s1 <= cond_bit;
            io_ready_s1 <= io_ready_previous;
            jump_previous_s1 <= jump_previous;
            destination_s1 <= hit ? destination : '0;
        end
    end

    // ----------------------------------------
    // stage 2 applies the I/O override and final mask
    // ----------------------------------------

    // if the previous instruction was not I/O ready it gets reissued,
    // and its flags are stale, so the earlier jump decision is reused
    assign decision = io_ready_s1 ? cond_bit_s1 : jump_previous_s1;

    // jump needs both the origin hit and a true decision
    assign jump_next = decision & hit_s1;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            jump <= 1'b0;
            destination_out <= '0;
        end else begin
            jump <= jump_next;
            // zeros from a non-jumping entry leave the OR at the top intact
            destination_out <= jump_next ? destination_s1 : '0;
        end
    end

endmodule

// ==== logic/branch_table.sv ====
/*
 * branch entry table
 * holds origin, destination and condition of one entry for every thread
 */

`timescale 1ns/1ps

module branch_table
    import branch_pkg::*;
#(
    parameter int THREAD_COUNT = 8,
    parameter int ENTRY_COUNT = 2,
    parameter int ENTRY_INDEX = 0
)
(
    input  logic                                    clock,
    input  logic                                    rst_n,
    branch_write_if.sink                            wr,
    input  logic [index_width(THREAD_COUNT)-1:0]    read_thread,
    output logic [PC_WIDTH-1:0]                     origin,
    output logic [PC_WIDTH-1:0]                     destination,
    output logic [COND_WIDTH-1:0]                   condition
);

    localparam int THREAD_ADDR_WIDTH = index_width(THREAD_COUNT);
    localparam int ENTRY_ADDR_WIDTH = index_width(ENTRY_COUNT);

    // one slot per thread for each field
    logic [PC_WIDTH-1:0] origin_mem [THREAD_COUNT];
    logic [PC_WIDTH-1:0] destination_mem [THREAD_COUNT];
    logic [COND_WIDTH-1:0] condition_mem [THREAD_COUNT];

    logic [ENTRY_ADDR_WIDTH-1:0] write_entry;
    logic [THREAD_ADDR_WIDTH-1:0] write_thread;
    logic entry_selected;

    // ----------------------------------------
    // write address decode
    // ----------------------------------------

    // upper bits pick the entry, lower bits the thread
    assign write_entry = wr.write_addr[THREAD_ADDR_WIDTH +: ENTRY_ADDR_WIDTH];
    assign write_thread = wr.write_addr[THREAD_ADDR_WIDTH-1:0];

    // all tables see every write, only the addressed entry takes it
    assign entry_selected = (write_entry == ENTRY_ADDR_WIDTH'(ENTRY_INDEX));

    // ----------------------------------------
    // storage
    // ----------------------------------------

    // a cleared slot has condition NEVER, so it can never branch
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int t = 0; t < THREAD_COUNT; t++) begin
                origin_mem[t] <= '0;
                destination_mem[t] <= '0;
                condition_mem[t] <= COND_NEVER;
            end
        end else if (entry_selected) begin
            if (wr.wren_origin) begin
                origin_mem[write_thread] <= wr.write_origin;
            end
            if (wr.wren_destination) begin
                destination_mem[write_thread] <= wr.write_destination;
            end
            if (wr.wren_condition) begin
                condition_mem[write_thread] <= wr.write_condition;
            end
        end
    end

    // the read is synchronous, so the caller addresses the thread that issues
    // next and the fields line up with the issuing thread one cycle later
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            origin <= '0;
            destination <= '0;
            condition <= COND_NEVER;
        end else begin
            origin <= origin_mem[read_thread];
            destination <= destination_mem[read_thread];
            condition <= condition_mem[read_thread];
        end
    end

endmodule

// ==== logic/branch_write_if.sv ====
/*
 * branch table write bus
 * ALU strobes, entry and thread address and the three data fields
 */

`timescale 1ns/1ps

interface branch_write_if
    import branch_pkg::*;
#(
    parameter int THREAD_COUNT = 8,
    parameter int ENTRY_COUNT = 2
);

    localparam int THREAD_ADDR_WIDTH = index_width(THREAD_COUNT);
    localparam int ENTRY_ADDR_WIDTH = index_width(ENTRY_COUNT);

    // one strobe per field, so the ALU can update a single field of an entry
    logic wren_origin;
    logic wren_destination;
    logic wren_condition;

    // entry index sits above the thread number
    logic [ENTRY_ADDR_WIDTH+THREAD_ADDR_WIDTH-1:0] write_addr;

    logic [PC_WIDTH-1:0] write_origin;
    logic [PC_WIDTH-1:0] write_destination;
    logic [COND_WIDTH-1:0] write_condition;

    modport source (
        output wren_origin, wren_destination, wren_condition,
        output write_addr, write_origin, write_destination, write_condition
    );

    modport sink (
        input wren_origin, wren_destination, wren_condition,
        input write_addr, write_origin, write_destination, write_condition
    );

endinterface

// ==== logic/branch_pkg.sv ====
/*
 * branch unit shared definitions
 * field widths and condition code encoding for the branch entries
 */

package branch_pkg;

    // a program counter addresses one instruction word
    localparam int PC_WIDTH = 10;

    // result flags of one thread's previous instruction
    localparam int FLAGS_WIDTH = 8;
    localparam int FLAG_SEL_WIDTH = $clog2(FLAGS_WIDTH);

    // ----------------------------------------
    // condition codes
    // ----------------------------------------
    localparam int COND_WIDTH = 4;

    localparam logic [COND_WIDTH-1:0] COND_NEVER = 4'd0;
    localparam logic [COND_WIDTH-1:0] COND_ALWAYS = 4'd1;

    // codes from the base upwards each pick one flag bit, the rest never jump
    localparam logic [COND_WIDTH-1:0] COND_FLAG_BASE = 4'd2;
    localparam logic [COND_WIDTH-1:0] COND_FLAG_LAST = COND_FLAG_BASE + COND_WIDTH'(FLAGS_WIDTH - 1);

    // width of an index into count items, never below one bit so that
    // a single thread or a single entry still gets a usable field
    function automatic int index_width(input int count);
        return (count > 1) ? $clog2(count) : 1;
    endfunction

endpackage
